//--- logic/clk_byp_consts.svh
// clock bypass constants
// divider count, token width and the encoded token values
`ifndef CLK_BYP_CONSTS_SVH
`define CLK_BYP_CONSTS_SVH

// number of step-down dividers
`define CLK_BYP_NUM_DIV 2

// width of every encoded token
`define CLK_BYP_TOK_W 4

// multi-bit boolean encodings
`define CLK_BYP_MUBI_TRUE 4'h6
`define CLK_BYP_MUBI_FALSE 4'h9

// life-cycle token encodings
`define CLK_BYP_LC_ON 4'hA
`define CLK_BYP_LC_OFF 4'h5

// divide ratios before step-down
`define CLK_BYP_DIV_RATIO0 2
`define CLK_BYP_DIV_RATIO1 4

`endif

//--- logic/clk_byp_pkg.sv
// clock bypass package
// multi-bit boolean and life-cycle token types, with strict value tests
`include "clk_byp_consts.svh"

package clk_byp_pkg;

  typedef enum logic [`CLK_BYP_TOK_W-1:0] {
    MUBI4_TRUE  = `CLK_BYP_MUBI_TRUE,
    MUBI4_FALSE = `CLK_BYP_MUBI_FALSE
  } mubi4_t;

  typedef enum logic [`CLK_BYP_TOK_W-1:0] {
    LC_ON  = `CLK_BYP_LC_ON,
    LC_OFF = `CLK_BYP_LC_OFF
  } lc_tx_t;

  // only the exact true pattern counts and anything else is false
  function automatic logic mubi4_test_true_strict(mubi4_t val);
    return val == MUBI4_TRUE;
  endfunction

  function automatic logic lc_tx_test_true_strict(lc_tx_t val);
    return val == LC_ON;
  endfunction

endpackage

//--- logic/clk_byp_token_sync.sv
// token synchronizer
// two flop stages plus a stability filter for one encoded token,
// so a glitch or a half-switched pattern never reaches the output
`timescale 1ns/1ps
`include "clk_byp_consts.svh"

module clk_byp_token_sync #(
  parameter logic [`CLK_BYP_TOK_W-1:0] RESET_VAL = '0
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic [`CLK_BYP_TOK_W-1:0] tok_i,
  output logic [`CLK_BYP_TOK_W-1:0] tok_o
);

  logic [`CLK_BYP_TOK_W-1:0] stage1_q;
  logic [`CLK_BYP_TOK_W-1:0] stage2_q;
  logic [`CLK_BYP_TOK_W-1:0] tok_q;
  logic                      stable;

  // both stages hold the same pattern
  assign stable = (stage1_q == stage2_q);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      stage1_q <= RESET_VAL;
      stage2_q <= RESET_VAL;
      tok_q    <= RESET_VAL;
    end else begin
      stage1_q <= tok_i;
      stage2_q <= stage1_q;
      // hold the last good value while the stages disagree
      if (stable) begin
        tok_q <= stage2_q;
      end
    end
  end

  assign tok_o = tok_q;

endmodule

//--- logic/clk_step_down_div.sv
// step-down clock divider
// produces a clock enable every RATIO cycles, or every RATIO/2 cycles
// once stepped down; mode and ack change only at a counter wrap
`timescale 1ns/1ps

module clk_step_down_div #(
  parameter int RATIO = 4
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  clk_byp_pkg::mubi4_t step_down_req_i,
  output logic                div_clk_en_o,
  output logic                step_down_ack_o
);

  localparam int CNT_W = (RATIO > 2) ? $clog2(RATIO) : 1;
  localparam logic [CNT_W-1:0] WRAP_FULL = CNT_W'(RATIO - 1);
  localparam logic [CNT_W-1:0] WRAP_HALF = CNT_W'(RATIO / 2 - 1);

  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] wrap_val;
  logic             wrap;
  logic             stepped_q;
  logic             en_q;
  logic             req_true;

  assign req_true = clk_byp_pkg::mubi4_test_true_strict(step_down_req_i);

  // terminal count depends on the current mode
  assign wrap_val = stepped_q ? WRAP_HALF : WRAP_FULL;
  assign wrap     = (cnt_q == wrap_val);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q     <= '0;
      stepped_q <= 1'b0;
      en_q      <= 1'b0;
    end else begin
      en_q <= wrap;
      if (wrap) begin
        cnt_q <= '0;
        // mode switch only here, so no short enable period
        stepped_q <= req_true;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign div_clk_en_o = en_q;

  // the ack is the mode itself and moves at the same wrap
  assign step_down_ack_o = stepped_q;

endmodule

//--- logic/clk_byp_ctrl.sv
// clock bypass controller
// forwards life-cycle and software bypass requests to the clock source,
// synchronizes the returning acks and answers the life-cycle controller
// once the source and every divider have switched
`timescale 1ns/1ps
`include "clk_byp_consts.svh"

module clk_byp_ctrl (
  input  logic                         clk_i,
  input  logic                         rst_i,
  // life-cycle controller side
  input  clk_byp_pkg::lc_tx_t          en_i,
  input  clk_byp_pkg::lc_tx_t          lc_clk_byp_req_i,
  output clk_byp_pkg::lc_tx_t          lc_clk_byp_ack_o,
  // software side
  input  clk_byp_pkg::mubi4_t          byp_req_i,
  output clk_byp_pkg::mubi4_t          byp_ack_o,
  input  clk_byp_pkg::mubi4_t          hi_speed_sel_i,
  // clock source side
  output clk_byp_pkg::mubi4_t          all_clk_byp_req_o,
  input  clk_byp_pkg::mubi4_t          all_clk_byp_ack_i,
  output clk_byp_pkg::mubi4_t          io_clk_byp_req_o,
  input  clk_byp_pkg::mubi4_t          io_clk_byp_ack_i,
  output clk_byp_pkg::mubi4_t          hi_speed_sel_o,
  // divider side
  input  logic [`CLK_BYP_NUM_DIV-1:0]  step_down_acks_i
);

  logic [`CLK_BYP_TOK_W-1:0]   en_sync;
  logic [`CLK_BYP_TOK_W-1:0]   lc_req_sync;
  logic [`CLK_BYP_TOK_W-1:0]   io_ack_sync;
  logic [`CLK_BYP_TOK_W-1:0]   all_ack_sync;
  logic [`CLK_BYP_NUM_DIV-1:0] step_down_acks_q;

  clk_byp_pkg::mubi4_t all_req_d;
  clk_byp_pkg::mubi4_t hi_speed_d;
  clk_byp_pkg::mubi4_t io_req_d;
  clk_byp_pkg::lc_tx_t lc_ack_d;
  logic                dividers_done;
  logic                io_ack_true;

  // life-cycle tokens
  clk_byp_token_sync #(.RESET_VAL(`CLK_BYP_LC_OFF)) i_en_sync (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .tok_i (en_i),
    .tok_o (en_sync)
  );

  clk_byp_token_sync #(.RESET_VAL(`CLK_BYP_LC_OFF)) i_lc_req_sync (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .tok_i (lc_clk_byp_req_i),
    .tok_o (lc_req_sync)
  );

  // acks coming back from the clock source
  clk_byp_token_sync #(.RESET_VAL(`CLK_BYP_MUBI_FALSE)) i_io_ack_sync (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .tok_i (io_clk_byp_ack_i),
    .tok_o (io_ack_sync)
  );

  clk_byp_token_sync #(.RESET_VAL(`CLK_BYP_MUBI_FALSE)) i_all_ack_sync (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .tok_i (all_clk_byp_ack_i),
    .tok_o (all_ack_sync)
  );

  // lc request goes straight on to the io clock source
  assign io_req_d =
    clk_byp_pkg::lc_tx_test_true_strict(clk_byp_pkg::lc_tx_t'(lc_req_sync)) ?
    clk_byp_pkg::MUBI4_TRUE : clk_byp_pkg::MUBI4_FALSE;

  // answer lc only once the source and all dividers confirm
  assign dividers_done = &step_down_acks_q;
  assign io_ack_true =
    clk_byp_pkg::mubi4_test_true_strict(clk_byp_pkg::mubi4_t'(io_ack_sync));
  assign lc_ack_d = (dividers_done && io_ack_true) ?
                    clk_byp_pkg::lc_tx_t'(lc_req_sync) : clk_byp_pkg::LC_OFF;

  // software request is gated by debug enable
  assign all_req_d =
    (clk_byp_pkg::mubi4_test_true_strict(byp_req_i) &&
     clk_byp_pkg::lc_tx_test_true_strict(clk_byp_pkg::lc_tx_t'(en_sync))) ?
    clk_byp_pkg::MUBI4_TRUE : clk_byp_pkg::MUBI4_FALSE;

  // high-speed select only means something during a software bypass
  assign hi_speed_d =
    (clk_byp_pkg::mubi4_test_true_strict(all_req_d) &&
     clk_byp_pkg::mubi4_test_true_strict(hi_speed_sel_i)) ?
    clk_byp_pkg::MUBI4_TRUE : clk_byp_pkg::MUBI4_FALSE;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      step_down_acks_q  <= '0;
      io_clk_byp_req_o  <= clk_byp_pkg::MUBI4_FALSE;
      lc_clk_byp_ack_o  <= clk_byp_pkg::LC_OFF;
      all_clk_byp_req_o <= clk_byp_pkg::MUBI4_FALSE;
      hi_speed_sel_o    <= clk_byp_pkg::MUBI4_TRUE;
    end else begin
      step_down_acks_q  <= step_down_acks_i;
      io_clk_byp_req_o  <= io_req_d;
      lc_clk_byp_ack_o  <= lc_ack_d;
      all_clk_byp_req_o <= all_req_d;
      hi_speed_sel_o    <= hi_speed_d;
    end
  end

  // software ack is the synchronized source ack
  assign byp_ack_o = clk_byp_pkg::mubi4_t'(all_ack_sync);

endmodule

//--- logic/clk_byp_top.sv
// clock bypass top level
// bypass controller plus the two step-down dividers that report to it
`timescale 1ns/1ps
`include "clk_byp_consts.svh"

module clk_byp_top (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  clk_byp_pkg::lc_tx_t         en_i,
  input  clk_byp_pkg::lc_tx_t         lc_clk_byp_req_i,
  output clk_byp_pkg::lc_tx_t         lc_clk_byp_ack_o,
  input  clk_byp_pkg::mubi4_t         byp_req_i,
  output clk_byp_pkg::mubi4_t         byp_ack_o,
  input  clk_byp_pkg::mubi4_t         hi_speed_sel_i,
  output clk_byp_pkg::mubi4_t         all_clk_byp_req_o,
  input  clk_byp_pkg::mubi4_t         all_clk_byp_ack_i,
  output clk_byp_pkg::mubi4_t         io_clk_byp_req_o,
  input  clk_byp_pkg::mubi4_t         io_clk_byp_ack_i,
  output clk_byp_pkg::mubi4_t         hi_speed_sel_o,
  input  clk_byp_pkg::mubi4_t         step_down_req_i,
  output logic [`CLK_BYP_NUM_DIV-1:0] div_clk_en_o
);

  logic [`CLK_BYP_NUM_DIV-1:0] step_down_acks;

  clk_byp_ctrl i_ctrl (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .en_i              (en_i),
    .lc_clk_byp_req_i  (lc_clk_byp_req_i),
    .lc_clk_byp_ack_o  (lc_clk_byp_ack_o),
    .byp_req_i         (byp_req_i),
    .byp_ack_o         (byp_ack_o),
    .hi_speed_sel_i    (hi_speed_sel_i),
    .all_clk_byp_req_o (all_clk_byp_req_o),
    .all_clk_byp_ack_i (all_clk_byp_ack_i),
    .io_clk_byp_req_o  (io_clk_byp_req_o),
    .io_clk_byp_ack_i  (io_clk_byp_ack_i),
    .hi_speed_sel_o    (hi_speed_sel_o),
    .step_down_acks_i  (step_down_acks)
  );

  // both dividers take the external step-down request directly
  clk_step_down_div #(.RATIO(`CLK_BYP_DIV_RATIO0)) i_div0 (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .step_down_req_i (step_down_req_i),
    .div_clk_en_o    (div_clk_en_o[0]),
    .step_down_ack_o (step_down_acks[0])
  );

  clk_step_down_div #(.RATIO(`CLK_BYP_DIV_RATIO1)) i_div1 (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .step_down_req_i (step_down_req_i),
    .div_clk_en_o    (div_clk_en_o[1]),
    .step_down_ack_o (step_down_acks[1])
  );

endmodule

//--- testbench/clk_byp_props.sv
// clock bypass controller checks
// bound into the controller, watches its registered outputs
`timescale 1ns/1ps

module clk_byp_props (
  input logic                clk_i,
  input logic                rst_i,
  input clk_byp_pkg::lc_tx_t lc_ack_i,
  input clk_byp_pkg::mubi4_t io_req_i,
  input clk_byp_pkg::mubi4_t all_req_i,
  input clk_byp_pkg::mubi4_t hi_speed_i,
  input clk_byp_pkg::mubi4_t byp_ack_i
);

  // number of failed assertions
  int fail_cnt = 0;

  // lc is only answered while its request is forwarded to the io source
  lc_ack_needs_io_req: assert property (
    @(posedge clk_i) disable iff (rst_i)
    lc_ack_i == clk_byp_pkg::LC_ON |-> io_req_i == clk_byp_pkg::MUBI4_TRUE
  ) else begin
    fail_cnt++;
    $error("lc bypass ack is ON without an io bypass request");
  end

  // high-speed select is reset to TRUE, so skip the first cycle out of reset
  hi_speed_needs_all_req: assert property (
    @(posedge clk_i) disable iff (rst_i)
    !$past(rst_i) && hi_speed_i == clk_byp_pkg::MUBI4_TRUE
      |-> all_req_i == clk_byp_pkg::MUBI4_TRUE
  ) else begin
    fail_cnt++;
    $error("high-speed select is TRUE without a software bypass request");
  end

  reset_values_held: assert property (
    @(posedge clk_i)
    rst_i && $past(rst_i) |->
      lc_ack_i == clk_byp_pkg::LC_OFF && io_req_i == clk_byp_pkg::MUBI4_FALSE &&
      all_req_i == clk_byp_pkg::MUBI4_FALSE && byp_ack_i == clk_byp_pkg::MUBI4_FALSE &&
      hi_speed_i == clk_byp_pkg::MUBI4_TRUE
  ) else begin
    fail_cnt++;
    $error("controller outputs left their reset values during reset");
  end

endmodule

bind clk_byp_ctrl clk_byp_props i_props (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .lc_ack_i   (lc_clk_byp_ack_o),
  .io_req_i   (io_clk_byp_req_o),
  .all_req_i  (all_clk_byp_req_o),
  .hi_speed_i (hi_speed_sel_o),
  .byp_ack_i  (byp_ack_o)
);

//--- testbench/tb_clk_byp.sv
// clock bypass testbench
// directed tests for software gating, the life-cycle handshake,
// glitch rejection and the step-down divider rates
`timescale 1ns/1ps
`include "clk_byp_consts.svh"

module tb_clk_byp;

  localparam int MAX_CYCLES = 3000;

  logic                        clk_i;
  logic                        rst_i;
  clk_byp_pkg::lc_tx_t         en_i;
  clk_byp_pkg::lc_tx_t         lc_clk_byp_req_i;
  clk_byp_pkg::lc_tx_t         lc_clk_byp_ack_o;
  clk_byp_pkg::mubi4_t         byp_req_i;
  clk_byp_pkg::mubi4_t         byp_ack_o;
  clk_byp_pkg::mubi4_t         hi_speed_sel_i;
  clk_byp_pkg::mubi4_t         all_clk_byp_req_o;
  clk_byp_pkg::mubi4_t         all_clk_byp_ack_i;
  clk_byp_pkg::mubi4_t         io_clk_byp_req_o;
  clk_byp_pkg::mubi4_t         io_clk_byp_ack_i;
  clk_byp_pkg::mubi4_t         hi_speed_sel_o;
  clk_byp_pkg::mubi4_t         step_down_req_i;
  logic [`CLK_BYP_NUM_DIV-1:0] div_clk_en_o;

  int error_cnt = 0;
  int cycle_cnt = 0;

  clk_byp_top i_dut (.*);

  always #2 clk_i = ~clk_i;

  // run limit of roughly ten times the length of all tests
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("run finished with %0d errors", error_cnt + 1);
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic compare_value(input string test, input logic [31:0] exp,
                               input logic [31:0] act);
    if (exp !== act) begin
      error_cnt++;
      $display("mismatch in %s: expected %0h, actual %0h", test, exp, act);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk_i);
  endtask

  // any pattern that is neither of the two valid encodings
  function automatic logic [3:0] random_invalid_token(input logic [3:0] on_val,
                                                      input logic [3:0] off_val);
    logic [3:0] val;
    val = 4'($urandom);
    while (val == on_val || val == off_val) begin
      val = 4'($urandom);
    end
    return val;
  endfunction

  task automatic settle_idle();
    en_i              = clk_byp_pkg::LC_OFF;
    lc_clk_byp_req_i  = clk_byp_pkg::LC_OFF;
    byp_req_i         = clk_byp_pkg::MUBI4_FALSE;
    hi_speed_sel_i    = clk_byp_pkg::MUBI4_FALSE;
    all_clk_byp_ack_i = clk_byp_pkg::MUBI4_FALSE;
    io_clk_byp_ack_i  = clk_byp_pkg::MUBI4_FALSE;
    step_down_req_i   = clk_byp_pkg::MUBI4_FALSE;
    wait_cycles(8);
  endtask

  task automatic wait_lc_ack(input string test, input int limit);
    int n;
    n = 0;
    while (lc_clk_byp_ack_o !== clk_byp_pkg::LC_ON && n < limit) begin
      wait_cycles(1);
      n++;
    end
    if (lc_clk_byp_ack_o !== clk_byp_pkg::LC_ON) begin
      error_cnt++;
      $display("%s: lc bypass ack never reached ON within %0d cycles", test, limit);
    end
  endtask

  task automatic count_enables(input int cycles, output int cnt0, output int cnt1);
    cnt0 = 0;
    cnt1 = 0;
    repeat (cycles) begin
      wait_cycles(1);
      cnt0 += int'(div_clk_en_o[0]);
      cnt1 += int'(div_clk_en_o[1]);
    end
  endtask

  // sampled while reset is still held
  task automatic check_reset_values();
    compare_value("reset_lc_ack", 32'(`CLK_BYP_LC_OFF), 32'(lc_clk_byp_ack_o));
    compare_value("reset_io_req", 32'(`CLK_BYP_MUBI_FALSE), 32'(io_clk_byp_req_o));
    compare_value("reset_all_req", 32'(`CLK_BYP_MUBI_FALSE), 32'(all_clk_byp_req_o));
    compare_value("reset_byp_ack", 32'(`CLK_BYP_MUBI_FALSE), 32'(byp_ack_o));
    compare_value("reset_hi_speed", 32'(`CLK_BYP_MUBI_TRUE), 32'(hi_speed_sel_o));
    compare_value("reset_div_en", 0, 32'(div_clk_en_o));
  endtask

  task automatic sw_bypass_gating();
    logic [3:0] byp_val;
    logic [3:0] hs_val;
    logic [3:0] exp_hs;
    en_i      = clk_byp_pkg::LC_ON;
    byp_req_i = clk_byp_pkg::MUBI4_TRUE;
    wait_cycles(4);
    compare_value("sw_en_on", 32'(`CLK_BYP_MUBI_TRUE), 32'(all_clk_byp_req_o));
    // all four combinations of request and high-speed select
    for (int i = 0; i < 4; i++) begin
      byp_val = i[0] ? `CLK_BYP_MUBI_TRUE : `CLK_BYP_MUBI_FALSE;
      hs_val  = i[1] ? `CLK_BYP_MUBI_TRUE : `CLK_BYP_MUBI_FALSE;
      exp_hs  = (i == 3) ? `CLK_BYP_MUBI_TRUE : `CLK_BYP_MUBI_FALSE;
      byp_req_i      = clk_byp_pkg::mubi4_t'(byp_val);
      hi_speed_sel_i = clk_byp_pkg::mubi4_t'(hs_val);
      wait_cycles(1);
      compare_value("sw_combo_req", 32'(byp_val), 32'(all_clk_byp_req_o));
      compare_value("sw_combo_hi_speed", 32'(exp_hs), 32'(hi_speed_sel_o));
    end
    byp_req_i = clk_byp_pkg::mubi4_t'(random_invalid_token(`CLK_BYP_MUBI_TRUE,
                                                          `CLK_BYP_MUBI_FALSE));
    wait_cycles(1);
    compare_value("sw_invalid_req", 32'(`CLK_BYP_MUBI_FALSE), 32'(all_clk_byp_req_o));
    compare_value("sw_invalid_hi", 32'(`CLK_BYP_MUBI_FALSE), 32'(hi_speed_sel_o));
    byp_req_i = clk_byp_pkg::MUBI4_TRUE;
    en_i      = clk_byp_pkg::LC_OFF;
    wait_cycles(4);
    compare_value("sw_en_off", 32'(`CLK_BYP_MUBI_FALSE), 32'(all_clk_byp_req_o));
    compare_value("sw_en_off_hi", 32'(`CLK_BYP_MUBI_FALSE), 32'(hi_speed_sel_o));
    // software ack follows the source ack three cycles later
    all_clk_byp_ack_i = clk_byp_pkg::MUBI4_TRUE;
    wait_cycles(2);
    compare_value("sw_ack_early", 32'(`CLK_BYP_MUBI_FALSE), 32'(byp_ack_o));
    wait_cycles(1);
    compare_value("sw_ack_rise", 32'(`CLK_BYP_MUBI_TRUE), 32'(byp_ack_o));
    all_clk_byp_ack_i = clk_byp_pkg::MUBI4_FALSE;
    wait_cycles(3);
    compare_value("sw_ack_fall", 32'(`CLK_BYP_MUBI_FALSE), 32'(byp_ack_o));
    settle_idle();
  endtask

  task automatic lc_bypass_handshake();
    lc_clk_byp_req_i = clk_byp_pkg::LC_ON;
    wait_cycles(3);
    compare_value("lc_req_early", 32'(`CLK_BYP_MUBI_FALSE), 32'(io_clk_byp_req_o));
    wait_cycles(1);
    compare_value("lc_req_fwd", 32'(`CLK_BYP_MUBI_TRUE), 32'(io_clk_byp_req_o));
    io_clk_byp_ack_i = clk_byp_pkg::MUBI4_TRUE;
    step_down_req_i  = clk_byp_pkg::MUBI4_TRUE;
    wait_lc_ack("lc_handshake", 20);
    lc_clk_byp_req_i = clk_byp_pkg::LC_OFF;
    wait_cycles(4);
    compare_value("lc_ack_drop", 32'(`CLK_BYP_LC_OFF), 32'(lc_clk_byp_ack_o));
    compare_value("lc_req_drop", 32'(`CLK_BYP_MUBI_FALSE), 32'(io_clk_byp_req_o));
    settle_idle();
  endtask

  task automatic ack_withheld();
    // source confirms but the dividers never step down, then the reverse
    for (int pass = 0; pass < 2; pass++) begin
      lc_clk_byp_req_i = clk_byp_pkg::LC_ON;
      io_clk_byp_ack_i = (pass == 0) ? clk_byp_pkg::MUBI4_TRUE : clk_byp_pkg::MUBI4_FALSE;
      step_down_req_i  = (pass == 0) ? clk_byp_pkg::MUBI4_FALSE : clk_byp_pkg::MUBI4_TRUE;
      repeat (30) begin
        wait_cycles(1);
        compare_value("ack_withheld", 32'(`CLK_BYP_LC_OFF), 32'(lc_clk_byp_ack_o));
      end
      settle_idle();
    end
  endtask

  task automatic glitch_rejection();
    lc_clk_byp_req_i = clk_byp_pkg::LC_ON;
    wait_cycles(1);
    lc_clk_byp_req_i = clk_byp_pkg::LC_OFF;
    repeat (8) begin
      wait_cycles(1);
      compare_value("glitch_lc_req", 32'(`CLK_BYP_MUBI_FALSE), 32'(io_clk_byp_req_o));
    end
    wait_cycles(2 + int'($urandom % 4));
    all_clk_byp_ack_i = clk_byp_pkg::MUBI4_TRUE;
    wait_cycles(1);
    all_clk_byp_ack_i = clk_byp_pkg::MUBI4_FALSE;
    repeat (8) begin
      wait_cycles(1);
      compare_value("glitch_all_ack", 32'(`CLK_BYP_MUBI_FALSE), 32'(byp_ack_o));
    end
    settle_idle();
  endtask

  task automatic divider_rates();
    int cnt0;
    int cnt1;
    count_enables(48, cnt0, cnt1);
    compare_value("div0_full", 48 / `CLK_BYP_DIV_RATIO0, cnt0);
    compare_value("div1_full", 48 / `CLK_BYP_DIV_RATIO1, cnt1);
    lc_clk_byp_req_i = clk_byp_pkg::LC_ON;
    io_clk_byp_ack_i = clk_byp_pkg::MUBI4_TRUE;
    step_down_req_i  = clk_byp_pkg::MUBI4_TRUE;
    wait_lc_ack("div_step_down", 20);
    count_enables(48, cnt0, cnt1);
    compare_value("div0_stepped", 48 / (`CLK_BYP_DIV_RATIO0 / 2), cnt0);
    compare_value("div1_stepped", 48 / (`CLK_BYP_DIV_RATIO1 / 2), cnt1);
    settle_idle();
  endtask

  initial begin
    void'($urandom(32'h9fcf_baf9));
    clk_i             = 1'b0;
    rst_i             = 1'b1;
    en_i              = clk_byp_pkg::LC_OFF;
    lc_clk_byp_req_i  = clk_byp_pkg::LC_OFF;
    byp_req_i         = clk_byp_pkg::MUBI4_FALSE;
    hi_speed_sel_i    = clk_byp_pkg::MUBI4_FALSE;
    all_clk_byp_ack_i = clk_byp_pkg::MUBI4_FALSE;
    io_clk_byp_ack_i  = clk_byp_pkg::MUBI4_FALSE;
    step_down_req_i   = clk_byp_pkg::MUBI4_FALSE;
    wait_cycles(8);
    check_reset_values();
    rst_i = 1'b0;
    wait_cycles(2);
    sw_bypass_gating();
    lc_bypass_handshake();
    ack_withheld();
    glitch_rejection();
    divider_rates();
    // failed assertions of the bound controller checker count as errors
    error_cnt += i_dut.i_ctrl.i_props.fail_cnt;
    $display("run finished with %0d errors", error_cnt);
    if (error_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+logic
logic/clk_byp_pkg.sv
logic/clk_byp_token_sync.sv
logic/clk_step_down_div.sv
logic/clk_byp_ctrl.sv
logic/clk_byp_top.sv
testbench/clk_byp_props.sv
testbench/tb_clk_byp.sv

//--- run_sim.sh
#!/bin/sh
# build and run the clock bypass testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f files.f --top-module tb_clk_byp \
  -Mdir obj_dir -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "TB FAILED" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi

echo "simulation finished cleanly"
